/* common/sya_pkg.sv */
// Shared widths, array size and types, imported by every engine module and the testbench
package sya_pkg;

    // Array size
    localparam int NUM_ROW = 4;
    localparam int NUM_COL = 4;

    // Data path widths
    localparam int ACT_WIDTH   = 8;
    localparam int ACC_WIDTH   = 26;
    localparam int ADDR_WIDTH  = 16;
    localparam int CHN_WIDTH   = 10;
    localparam int IDX_WIDTH   = 8;
    localparam int SHIFT_WIDTH = 5;

    // Smallest channel count that keeps consecutive tiles apart in the collector
    localparam int MIN_CHN = 7;

    typedef logic signed [ACT_WIDTH-1:0] act_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;
    typedef logic [ADDR_WIDTH-1:0]       addr_t;
    typedef logic [CHN_WIDTH-1:0]        chn_t;
    typedef logic [IDX_WIDTH-1:0]        idx_t;
    typedef logic [SHIFT_WIDTH-1:0]      shift_t;

    // One row vector, one column vector, one result row
    typedef act_t [NUM_ROW-1:0] act_vec_t;
    typedef act_t [NUM_COL-1:0] wgt_vec_t;
    typedef act_t [NUM_COL-1:0] ofm_row_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ISSUE,
        CTRL_DRAIN
    } ctrl_state_e;

endpackage

/* logic/sya_loop_ctrl.sv */
// Job controller: takes the configuration, walks the tiles, issues read addresses, ends the job
`timescale 1ns/1ps

module sya_loop_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_vld,
    output logic            cfg_rdy,
    input  sya_pkg::shift_t cfg_shift,
    input  sya_pkg::act_t   cfg_zp,
    input  sya_pkg::chn_t   cfg_chn,
    input  sya_pkg::idx_t   cfg_num_til_ifm,
    input  sya_pkg::idx_t   cfg_num_til_flt,
    input  sya_pkg::addr_t  cfg_act_base,
    input  sya_pkg::addr_t  cfg_wgt_base,
    input  sya_pkg::addr_t  cfg_ofm_base,
    output sya_pkg::addr_t  act_addr,
    output sya_pkg::addr_t  wgt_addr,
    output logic            rd_addr_vld,
    input  logic            act_addr_rdy,
    input  logic            wgt_addr_rdy,
    input  logic            act_dat_vld,
    input  logic            wgt_dat_vld,
    input  logic            adv,
    input  logic            tile_done,
    output logic            rd_dat_rdy,
    output logic            in_vld,
    output logic            in_last,
    output sya_pkg::shift_t shift,
    output sya_pkg::act_t   zp,
    output sya_pkg::addr_t  ofm_base
);
    import sya_pkg::*;

    ctrl_state_e state, state_nxt;

    chn_t  chn_q;
    idx_t  num_ifm_q, num_flt_q;
    addr_t act_base_q, wgt_base_q;

    chn_t  chn_cnt, dat_cnt;
    idx_t  flt_cnt, ifm_cnt;
    addr_t act_off, wgt_off;
    logic [2*IDX_WIDTH-1:0] done_cnt;

    logic cfg_hs, addr_hs, dat_hs;
    logic chn_wrap, flt_wrap, ifm_wrap;

    assign cfg_rdy     = (state == CTRL_IDLE);
    assign cfg_hs      = cfg_vld & cfg_rdy;
    assign rd_addr_vld = (state == CTRL_ISSUE);
    assign addr_hs     = rd_addr_vld & act_addr_rdy & wgt_addr_rdy;

    assign chn_wrap = (chn_cnt == chn_q - 1'b1);
    assign flt_wrap = (flt_cnt == num_flt_q - 1'b1);
    assign ifm_wrap = (ifm_cnt == num_ifm_q - 1'b1);

    assign act_addr = act_base_q + act_off + chn_cnt;
    assign wgt_addr = wgt_base_q + wgt_off + chn_cnt;

    // Data side, the array takes a word only when it advances
    assign rd_dat_rdy = adv;
    assign in_vld     = act_dat_vld & wgt_dat_vld;
    assign in_last    = (dat_cnt == chn_q - 1'b1);
    assign dat_hs     = in_vld & adv;

    // ========================================================================
    // Job FSM
    // ========================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            CTRL_IDLE: begin
                if (cfg_hs) begin
                    state_nxt = CTRL_ISSUE;
                end
            end
            CTRL_ISSUE: begin
                if (addr_hs && chn_wrap && flt_wrap && ifm_wrap) begin
                    state_nxt = CTRL_DRAIN;
                end
            end
            CTRL_DRAIN: begin
                if (done_cnt == num_ifm_q * num_flt_q) begin
                    state_nxt = CTRL_IDLE;
                end
            end
            default: begin
                state_nxt = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Job settings; the output base steps one tile on every finished tile
    always_ff @(posedge clk) begin
        if (cfg_hs) begin
            shift      <= cfg_shift;
            zp         <= cfg_zp;
            chn_q      <= cfg_chn;
            num_ifm_q  <= cfg_num_til_ifm;
            num_flt_q  <= cfg_num_til_flt;
            act_base_q <= cfg_act_base;
            wgt_base_q <= cfg_wgt_base;
            ofm_base   <= cfg_ofm_base;
        end else if (tile_done) begin
            ofm_base <= ofm_base + addr_t'(NUM_ROW);
        end
    end

    // ========================================================================
    // Address walk: channel inner, filter tile middle, feature tile outer
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chn_cnt <= '0;
            flt_cnt <= '0;
            ifm_cnt <= '0;
            act_off <= '0;
            wgt_off <= '0;
        end else if (cfg_hs) begin
            chn_cnt <= '0;
            flt_cnt <= '0;
            ifm_cnt <= '0;
            act_off <= '0;
            wgt_off <= '0;
        end else if (addr_hs) begin
            if (!chn_wrap) begin
                chn_cnt <= chn_cnt + 1'b1;
            end else begin
                chn_cnt <= '0;
                if (!flt_wrap) begin
                    flt_cnt <= flt_cnt + 1'b1;
                    wgt_off <= wgt_off + chn_q;
                end else begin
                    flt_cnt <= '0;
                    wgt_off <= '0;
                    ifm_cnt <= ifm_cnt + 1'b1;
                    act_off <= act_off + chn_q;
                end
            end
        end
    end

    // Channel position of the incoming data and finished tile count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dat_cnt  <= '0;
            done_cnt <= '0;
        end else begin
            if (dat_hs) begin
                dat_cnt <= in_last ? '0 : dat_cnt + 1'b1;
            end
            if (cfg_hs) begin
                done_cnt <= '0;
            end else if (tile_done) begin
                done_cnt <= done_cnt + 1'b1;
            end
        end
    end

endmodule

/* pe_array/sya_pe.sv */
// Multiply-accumulate cell of the systolic grid, with forwarding and requantization
`timescale 1ns/1ps

module sya_pe (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            adv,
    input  sya_pkg::shift_t shift,
    input  sya_pkg::act_t   zp,
    input  sya_pkg::act_t   act_in,
    input  sya_pkg::act_t   wgt_in,
    input  logic            vld_in,
    input  logic            last_in,
    output sya_pkg::act_t   act_out,
    output sya_pkg::act_t   wgt_out,
    output logic            vld_out,
    output logic            last_out,
    output sya_pkg::act_t   res,
    output logic            res_vld
);
    import sya_pkg::*;

    acc_t prod_q, acc_q, acc_sum;
    logic prod_vld, prod_last;

    // Arithmetic shift, zero point, then clamp to int8
    function automatic act_t requant(acc_t sum, shift_t sh, act_t bias);
        acc_t val;
        val = (sum >>> sh) + acc_t'(bias);
        if (val > acc_t'(127)) begin
            return act_t'(127);
        end else if (val < acc_t'(-128)) begin
            return act_t'(-128);
        end
        return val[ACT_WIDTH-1:0];
    endfunction

    assign acc_sum = acc_q + prod_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_out   <= 1'b0;
            last_out  <= 1'b0;
            prod_vld  <= 1'b0;
            prod_last <= 1'b0;
            acc_q     <= '0;
            res_vld   <= 1'b0;
        end else if (adv) begin
            vld_out   <= vld_in;
            last_out  <= last_in;
            prod_vld  <= vld_in;
            prod_last <= vld_in & last_in;
            res_vld   <= prod_vld & prod_last;
            // Next tile starts from zero
            if (prod_vld) begin
                acc_q <= prod_last ? '0 : acc_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            act_out <= act_in;
            wgt_out <= wgt_in;
            prod_q  <= act_in * wgt_in;
            if (prod_vld && prod_last) begin
                res <= requant(acc_sum, shift, zp);
            end
        end
    end

endmodule

/* pe_array/sya_pe_array.sv */
// Input skew and the 4 by 4 grid of cells; activations flow east, weights flow south
`timescale 1ns/1ps

module sya_pe_array (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               adv,
    input  sya_pkg::shift_t    shift,
    input  sya_pkg::act_t      zp,
    input  sya_pkg::act_vec_t  act_dat,
    input  sya_pkg::wgt_vec_t  wgt_dat,
    input  logic               in_vld,
    input  logic               in_last,
    output sya_pkg::act_t [sya_pkg::NUM_ROW-1:0][sya_pkg::NUM_COL-1:0] res,
    output logic [sya_pkg::NUM_ROW-1:0][sya_pkg::NUM_COL-1:0]          res_vld
);
    import sya_pkg::*;

    // Horizontal and vertical links, one extra at the far edge
    act_t act_h  [NUM_ROW][NUM_COL+1];
    logic vld_h  [NUM_ROW][NUM_COL+1];
    logic last_h [NUM_ROW][NUM_COL+1];
    act_t wgt_v  [NUM_ROW+1][NUM_COL];

    // Row r waits r cycles, flags travel with the activations
    for (genvar r = 0; r < NUM_ROW; r++) begin : g_act_skew
        if (r == 0) begin : g_direct
            assign act_h[r][0]  = act_dat[r];
            assign vld_h[r][0]  = in_vld;
            assign last_h[r][0] = in_last;
        end else begin : g_dly
            act_t act_sr  [r];
            logic vld_sr  [r];
            logic last_sr [r];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int k = 0; k < r; k++) begin
                        vld_sr[k]  <= 1'b0;
                        last_sr[k] <= 1'b0;
                    end
                end else if (adv) begin
                    vld_sr[0]  <= in_vld;
                    last_sr[0] <= in_last;
                    for (int k = 1; k < r; k++) begin
                        vld_sr[k]  <= vld_sr[k-1];
                        last_sr[k] <= last_sr[k-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (adv) begin
                    act_sr[0] <= act_dat[r];
                    for (int k = 1; k < r; k++) begin
                        act_sr[k] <= act_sr[k-1];
                    end
                end
            end

            assign act_h[r][0]  = act_sr[r-1];
            assign vld_h[r][0]  = vld_sr[r-1];
            assign last_h[r][0] = last_sr[r-1];
        end
    end

    // Column c waits c cycles
    for (genvar c = 0; c < NUM_COL; c++) begin : g_wgt_skew
        if (c == 0) begin : g_direct
            assign wgt_v[0][c] = wgt_dat[c];
        end else begin : g_dly
            act_t wgt_sr [c];

            always_ff @(posedge clk) begin
                if (adv) begin
                    wgt_sr[0] <= wgt_dat[c];
                    for (int k = 1; k < c; k++) begin
                        wgt_sr[k] <= wgt_sr[k-1];
                    end
                end
            end

            assign wgt_v[0][c] = wgt_sr[c-1];
        end
    end

    for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
        for (genvar c = 0; c < NUM_COL; c++) begin : g_col
            sya_pe u_pe (
                .clk      (clk),
                .rst_n    (rst_n),
                .adv      (adv),
                .shift    (shift),
                .zp       (zp),
                .act_in   (act_h[r][c]),
                .wgt_in   (wgt_v[r][c]),
                .vld_in   (vld_h[r][c]),
                .last_in  (last_h[r][c]),
                .act_out  (act_h[r][c+1]),
                .wgt_out  (wgt_v[r+1][c]),
                .vld_out  (vld_h[r][c+1]),
                .last_out (last_h[r][c+1]),
                .res      (res[r][c]),
                .res_vld  (res_vld[r][c])
            );
        end
    end

endmodule

/* logic/sya_ofm_collect.sv */
// Result tile buffer: gathers the skewed cell results, stalls the array, writes rows out
`timescale 1ns/1ps

module sya_ofm_collect (
    input  logic              clk,
    input  logic              rst_n,
    input  sya_pkg::act_t [sya_pkg::NUM_ROW-1:0][sya_pkg::NUM_COL-1:0] res,
    input  logic [sya_pkg::NUM_ROW-1:0][sya_pkg::NUM_COL-1:0]          res_vld,
    input  sya_pkg::addr_t    ofm_base,
    input  logic              ofm_rdy,
    output logic              adv,
    output logic              tile_done,
    output sya_pkg::ofm_row_t ofm_dat,
    output sya_pkg::addr_t    ofm_addr,
    output logic              ofm_vld
);
    import sya_pkg::*;

    act_t [NUM_ROW-1:0][NUM_COL-1:0] tile_q;
    logic [NUM_ROW-1:0][NUM_COL-1:0] held;
    logic [$clog2(NUM_ROW)-1:0]      wr_row;
    logic                            wr_hs;

    // Full tile freezes the array until the last row leaves
    assign ofm_vld   = &held;
    assign adv       = ~ofm_vld;
    assign wr_hs     = ofm_vld & ofm_rdy;
    assign tile_done = wr_hs && (wr_row == NUM_ROW - 1);

    assign ofm_dat  = tile_q[wr_row];
    assign ofm_addr = ofm_base + wr_row;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held   <= '0;
            wr_row <= '0;
        end else begin
            if (tile_done) begin
                held <= '0;
            end else if (adv) begin
                held <= held | res_vld;
            end
            if (wr_hs) begin
                wr_row <= wr_row + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                for (int c = 0; c < NUM_COL; c++) begin
                    if (res_vld[r][c]) begin
                        tile_q[r][c] <= res[r][c];
                    end
                end
            end
        end
    end

endmodule

/* logic/sya_top.sv */
// Top level of the int8 systolic matrix engine, joining controller, array and collector
`timescale 1ns/1ps

module sya_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_vld,
    output logic              cfg_rdy,
    input  sya_pkg::shift_t   cfg_shift,
    input  sya_pkg::act_t     cfg_zp,
    input  sya_pkg::chn_t     cfg_chn,
    input  sya_pkg::idx_t     cfg_num_til_ifm,
    input  sya_pkg::idx_t     cfg_num_til_flt,
    input  sya_pkg::addr_t    cfg_act_base,
    input  sya_pkg::addr_t    cfg_wgt_base,
    input  sya_pkg::addr_t    cfg_ofm_base,
    output sya_pkg::addr_t    act_addr,
    output sya_pkg::addr_t    wgt_addr,
    output logic              rd_addr_vld,
    input  logic              act_addr_rdy,
    input  logic              wgt_addr_rdy,
    input  sya_pkg::act_vec_t act_dat,
    input  logic              act_dat_vld,
    input  sya_pkg::wgt_vec_t wgt_dat,
    input  logic              wgt_dat_vld,
    output logic              rd_dat_rdy,
    output sya_pkg::ofm_row_t ofm_dat,
    output sya_pkg::addr_t    ofm_addr,
    output logic              ofm_vld,
    input  logic              ofm_rdy
);
    import sya_pkg::*;

    logic   adv, tile_done;
    logic   in_vld, in_last;
    shift_t shift;
    act_t   zp;
    addr_t  ofm_base;

    act_t [NUM_ROW-1:0][NUM_COL-1:0] res;
    logic [NUM_ROW-1:0][NUM_COL-1:0] res_vld;

    sya_loop_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_shift       (cfg_shift),
        .cfg_zp          (cfg_zp),
        .cfg_chn         (cfg_chn),
        .cfg_num_til_ifm (cfg_num_til_ifm),
        .cfg_num_til_flt (cfg_num_til_flt),
        .cfg_act_base    (cfg_act_base),
        .cfg_wgt_base    (cfg_wgt_base),
        .cfg_ofm_base    (cfg_ofm_base),
        .act_addr        (act_addr),
        .wgt_addr        (wgt_addr),
        .rd_addr_vld     (rd_addr_vld),
        .act_addr_rdy    (act_addr_rdy),
        .wgt_addr_rdy    (wgt_addr_rdy),
        .act_dat_vld     (act_dat_vld),
        .wgt_dat_vld     (wgt_dat_vld),
        .adv             (adv),
        .tile_done       (tile_done),
        .rd_dat_rdy      (rd_dat_rdy),
        .in_vld          (in_vld),
        .in_last         (in_last),
        .shift           (shift),
        .zp              (zp),
        .ofm_base        (ofm_base)
    );

    sya_pe_array u_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .adv     (adv),
        .shift   (shift),
        .zp      (zp),
        .act_dat (act_dat),
        .wgt_dat (wgt_dat),
        .in_vld  (in_vld),
        .in_last (in_last),
        .res     (res),
        .res_vld (res_vld)
    );

    sya_ofm_collect u_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res),
        .res_vld   (res_vld),
        .ofm_base  (ofm_base),
        .ofm_rdy   (ofm_rdy),
        .adv       (adv),
        .tile_done (tile_done),
        .ofm_dat   (ofm_dat),
        .ofm_addr  (ofm_addr),
        .ofm_vld   (ofm_vld)
    );

endmodule

/* tb/sya_tb.sv */
// Testbench for the systolic matrix engine; runs the job table against a buffer model
`timescale 1ns/1ps

module sya_tb;
    import sya_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int MEM_DEPTH   = 2048;
    localparam int NUM_JOBS    = 8;
    localparam int WORD_CYCLES = 12;
    localparam int TILE_CYCLES = 40;
    localparam int JOB_CYCLES  = 100;

    typedef struct packed {
        chn_t   chn;
        idx_t   n_ifm;
        idx_t   n_flt;
        shift_t shift;
        act_t   zp;
        addr_t  act_base;
        addr_t  wgt_base;
        addr_t  ofm_base;
        logic   bp;
        logic   wide;
    } job_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      cfg_vld, cfg_rdy;
    shift_t    cfg_shift;
    act_t      cfg_zp;
    chn_t      cfg_chn;
    idx_t      cfg_num_til_ifm, cfg_num_til_flt;
    addr_t     cfg_act_base, cfg_wgt_base, cfg_ofm_base;
    addr_t     act_addr, wgt_addr;
    logic      rd_addr_vld, act_addr_rdy, wgt_addr_rdy;
    act_vec_t  act_dat;
    wgt_vec_t  wgt_dat;
    logic      act_dat_vld, wgt_dat_vld, rd_dat_rdy;
    ofm_row_t  ofm_dat;
    addr_t     ofm_addr;
    logic      ofm_vld, ofm_rdy;

    // Buffer model state
    act_vec_t act_mem [MEM_DEPTH];
    wgt_vec_t wgt_mem [MEM_DEPTH];
    addr_t    act_q [$];
    addr_t    wgt_q [$];

    job_t jobs [NUM_JOBS];
    job_t cur;
    logic bp_on;
    int   wr_cnt;
    int   rd_cnt;
    int   exp_writes;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sya_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_shift       (cfg_shift),
        .cfg_zp          (cfg_zp),
        .cfg_chn         (cfg_chn),
        .cfg_num_til_ifm (cfg_num_til_ifm),
        .cfg_num_til_flt (cfg_num_til_flt),
        .cfg_act_base    (cfg_act_base),
        .cfg_wgt_base    (cfg_wgt_base),
        .cfg_ofm_base    (cfg_ofm_base),
        .act_addr        (act_addr),
        .wgt_addr        (wgt_addr),
        .rd_addr_vld     (rd_addr_vld),
        .act_addr_rdy    (act_addr_rdy),
        .wgt_addr_rdy    (wgt_addr_rdy),
        .act_dat         (act_dat),
        .act_dat_vld     (act_dat_vld),
        .wgt_dat         (wgt_dat),
        .wgt_dat_vld     (wgt_dat_vld),
        .rd_dat_rdy      (rd_dat_rdy),
        .ofm_dat         (ofm_dat),
        .ofm_addr        (ofm_addr),
        .ofm_vld         (ofm_vld),
        .ofm_rdy         (ofm_rdy)
    );

    // ========================================================================
    // Failure reporting and compare tasks
    // ========================================================================
    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_row(ofm_row_t got, ofm_row_t exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            $display("FAIL at %0t: %s got %0d expected %0d", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    // ========================================================================
    // Stimulus table and reference model
    // ========================================================================
    function automatic job_t make_job(int chn, int n_ifm, int n_flt, int sh, int zp,
                                      int act_base, int wgt_base, int ofm_base,
                                      bit bp, bit wide);
        job_t job;
        job.chn      = chn_t'(chn);
        job.n_ifm    = idx_t'(n_ifm);
        job.n_flt    = idx_t'(n_flt);
        job.shift    = shift_t'(sh);
        job.zp       = act_t'(zp);
        job.act_base = addr_t'(act_base);
        job.wgt_base = addr_t'(wgt_base);
        job.ofm_base = addr_t'(ofm_base);
        job.bp       = bp;
        job.wide     = wide;
        return job;
    endfunction

    task automatic load_table();
        // chn, ifm tiles, flt tiles, shift, zp, act/wgt/ofm base, stalls, wide values
        jobs[0] = make_job(8,  1, 1, 0, 0,   'h000, 'h000, 'h0000, 1'b0, 1'b0);
        jobs[1] = make_job(16, 1, 1, 4, 20,  'h020, 'h020, 'h0010, 1'b0, 1'b1);
        jobs[2] = make_job(12, 2, 1, 6, -35, 'h040, 'h040, 'h0020, 1'b0, 1'b1);
        jobs[3] = make_job(9,  2, 3, 0, -3,  'h100, 'h100, 'h0100, 1'b0, 1'b0);
        jobs[4] = make_job(9,  2, 3, 0, -3,  'h100, 'h100, 'h0100, 1'b1, 1'b0);
        jobs[5] = make_job(7,  3, 2, 1, 5,   'h200, 'h200, 'h0300, 1'b0, 1'b0);
        jobs[6] = make_job(7,  2, 3, 9, -7,  'h300, 'h300, 'h0800, 1'b1, 1'b1);
        jobs[7] = make_job(20, 1, 2, 3, 100, 'h400, 'h400, 'hfff8, 1'b1, 1'b1);
    endtask

    function automatic act_t rand_value(bit wide);
        if (wide) begin
            return act_t'($urandom_range(0, 255));
        end
        return act_t'(int'($urandom_range(0, 6)) - 3);
    endfunction

    task automatic fill_memories(bit wide);
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int e = 0; e < NUM_ROW; e++) begin
                act_mem[a][e] = rand_value(wide);
            end
            for (int e = 0; e < NUM_COL; e++) begin
                wgt_mem[a][e] = rand_value(wide);
            end
        end
    endtask

    // Row r of tile t, i outer and f inner
    function automatic ofm_row_t expect_row(int t, int r);
        ofm_row_t row;
        longint   sum;
        int       i, f;
        addr_t    a_adr, w_adr;
        i = t / int'(cur.n_flt);
        f = t % int'(cur.n_flt);
        for (int c = 0; c < NUM_COL; c++) begin
            sum = 0;
            for (int k = 0; k < int'(cur.chn); k++) begin
                a_adr = addr_t'(int'(cur.act_base) + i * int'(cur.chn) + k);
                w_adr = addr_t'(int'(cur.wgt_base) + f * int'(cur.chn) + k);
                sum += longint'(act_mem[a_adr % MEM_DEPTH][r])
                     * longint'(wgt_mem[w_adr % MEM_DEPTH][c]);
            end
            sum = (sum >>> cur.shift) + longint'(cur.zp);
            if (sum > 127) begin
                sum = 127;
            end else if (sum < -128) begin
                sum = -128;
            end
            row[c] = act_t'(sum);
        end
        return row;
    endfunction

    // ========================================================================
    // Buffer model, one call per clock cycle
    // ========================================================================
    function automatic logic random_stall(int one_in);
        return bp_on && ($urandom_range(0, one_in - 1) == 0);
    endfunction

    // Read n is channel n % chn of tile pair n / chn, i outer and f inner
    task automatic record_read();
        int k, t, i, f;
        k = rd_cnt % int'(cur.chn);
        t = rd_cnt / int'(cur.chn);
        i = t / int'(cur.n_flt);
        f = t % int'(cur.n_flt);
        if (t >= exp_writes / NUM_ROW) begin
            check_count(rd_cnt + 1, int'(cur.chn) * exp_writes / NUM_ROW, "read addresses");
        end
        check_addr(act_addr, addr_t'(int'(cur.act_base) + i * int'(cur.chn) + k), "act_addr");
        check_addr(wgt_addr, addr_t'(int'(cur.wgt_base) + f * int'(cur.chn) + k), "wgt_addr");
        act_q.push_back(act_addr);
        wgt_q.push_back(wgt_addr);
        rd_cnt++;
    endtask

    task automatic record_write();
        int t, r;
        if (wr_cnt >= exp_writes) begin
            check_count(wr_cnt + 1, exp_writes, "output writes");
        end
        t = wr_cnt / NUM_ROW;
        r = wr_cnt % NUM_ROW;
        check_addr(ofm_addr, addr_t'(int'(cur.ofm_base) + t * NUM_ROW + r), "ofm_addr");
        check_row(ofm_dat, expect_row(t, r), "ofm_dat");
        wr_cnt++;
    endtask

    // DUT outputs come from registers, so the handshakes are settled at the falling edge
    task automatic step_cycle();
        @(negedge clk);
        if (act_q.size() > 0) begin
            act_dat     = act_mem[act_q[0] % MEM_DEPTH];
            wgt_dat     = wgt_mem[wgt_q[0] % MEM_DEPTH];
            act_dat_vld = !random_stall(4);
            wgt_dat_vld = !random_stall(4);
            if (act_dat_vld && wgt_dat_vld && rd_dat_rdy) begin
                void'(act_q.pop_front());
                void'(wgt_q.pop_front());
            end
        end else begin
            act_dat_vld = 1'b0;
            wgt_dat_vld = 1'b0;
        end
        act_addr_rdy = !random_stall(4);
        wgt_addr_rdy = !random_stall(4);
        if (rd_addr_vld && act_addr_rdy && wgt_addr_rdy) begin
            record_read();
        end
        ofm_rdy = !random_stall(3);
        if (ofm_vld && ofm_rdy) begin
            record_write();
        end
    endtask

    task automatic run_job(job_t job);
        int wait_cnt;
        cur        = job;
        bp_on      = job.bp;
        wr_cnt     = 0;
        rd_cnt     = 0;
        exp_writes = NUM_ROW * int'(job.n_ifm) * int'(job.n_flt);
        fill_memories(job.wide);
        step_cycle();
        while (!cfg_rdy) begin
            step_cycle();
        end
        cfg_vld         = 1'b1;
        cfg_shift       = job.shift;
        cfg_zp          = job.zp;
        cfg_chn         = job.chn;
        cfg_num_til_ifm = job.n_ifm;
        cfg_num_til_flt = job.n_flt;
        cfg_act_base    = job.act_base;
        cfg_wgt_base    = job.wgt_base;
        cfg_ofm_base    = job.ofm_base;
        step_cycle();
        cfg_vld = 1'b0;
        // Job ends when cfg_rdy rises again
        wait_cnt = 0;
        while (!cfg_rdy) begin
            if (wait_cnt == 8) begin
                $display("cfg_rdy stayed low after the final write of a job");
                end_with_failure();
            end else begin
                step_cycle();
                if (wr_cnt == exp_writes) begin
                    wait_cnt++;
                end
            end
        end
        check_count(wr_cnt, exp_writes, "output writes");
    endtask

    initial begin
        longint budget;
        void'($urandom(32'h39f8_0d67));
        rst_n           = 1'b0;
        cfg_vld         = 1'b0;
        cfg_shift       = '0;
        cfg_zp          = '0;
        cfg_chn         = '0;
        cfg_num_til_ifm = '0;
        cfg_num_til_flt = '0;
        cfg_act_base    = '0;
        cfg_wgt_base    = '0;
        cfg_ofm_base    = '0;
        act_addr_rdy    = 1'b0;
        wgt_addr_rdy    = 1'b0;
        act_dat         = '0;
        wgt_dat         = '0;
        act_dat_vld     = 1'b0;
        wgt_dat_vld     = 1'b0;
        ofm_rdy         = 1'b0;
        bp_on           = 1'b0;
        load_table();

        // Cycle budget grows with channels and tiles of every job
        budget = JOB_CYCLES;
        for (int j = 0; j < NUM_JOBS; j++) begin
            budget += longint'(jobs[j].n_ifm) * longint'(jobs[j].n_flt)
                    * (longint'(jobs[j].chn) * WORD_CYCLES + TILE_CYCLES) + JOB_CYCLES;
        end
        fork
            begin
                #(budget * CLK_PERIOD);
                $display("Timeout: the engine did not finish within %0d clock cycles", budget);
                end_with_failure();
            end
        join_none

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(jobs[j]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* src.f */
common/sya_pkg.sv
logic/sya_loop_ctrl.sv
pe_array/sya_pe.sv
pe_array/sya_pe_array.sv
logic/sya_ofm_collect.sv
logic/sya_top.sv
tb/sya_tb.sv

/* Bender.yml */
package:
  name: sya

sources:
  - common/sya_pkg.sv
  - logic/sya_loop_ctrl.sv
  - pe_array/sya_pe.sv
  - pe_array/sya_pe_array.sv
  - logic/sya_ofm_collect.sv
  - logic/sya_top.sv
  - target: test
    files:
      - tb/sya_tb.sv
